//--- filelist.f
+incdir+.
rv_pkg.sv
rv_decoder.sv
rv_alu.sv
rv_regfile.sv
rv_fetch.sv
rv_data_mem.sv
rv_core.sv
tb_rv_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the rv_core testbench with Verilator, run it and check the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_rv_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_rv_core)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" <<< "$output"; then
    exit 0
else
    echo "simulation reported failures"
    exit 1
fi

//--- tb_rv_core.sv
////////////////////
// Directed testbench for rv_core.
// Programs are assembled here, loaded while reset is low and then run.
// A reference model of registers, data memory and pc predicts
// every retirement; each program ends in a jal-to-self halt.
////////////////////
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_rv_core import rv_pkg::*;;

    logic       clk;
    logic       reset_b;
    logic       prog_we;
    imem_addr_t prog_addr;
    word_t      prog_data;
    word_t      pc;
    wb_t        wb;

    word_t  prog [$];              // program being assembled
    word_t  model_imem [0:255];
    word_t  model_dmem [0:(1<<`RV_DMEM_AW)-1];
    word_t  model_regs [0:31];
    word_t  model_pc;
    logic   halted;
    integer seed = 32'h4aa8;
    string  cur_test;
    int     errors;
    int     test_errors_at_start;
    int     tests_passed;
    int     tests_failed;

    rv_core u_dut (
        .clk       (clk),
        .reset_b   (reset_b),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc        (pc),
        .wb        (wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // instruction encoders in the RV32I field layouts
    function automatic word_t rr_inst(input int f7, input int f3, input int rd,
                                      input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t i_inst(input int f3, input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic word_t lw_inst(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic word_t sw_inst(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t br_inst(input int f3, input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic word_t lui_inst(input int rd, input word_t value);
        return {value[31:12], rd[4:0], 7'b0110111};
    endfunction

    function automatic word_t jal_inst(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    // lui plus addi with the upper part rounded for the sign-extended low half
    task automatic emit_li(input int rd, input word_t value);
        word_t hi;
        hi = value + 32'h800;
        prog.push_back(lui_inst(rd, hi));
        prog.push_back(i_inst(0, rd, rd, int'(value)));
    endtask

    // branch over one marker write to x20
    task automatic emit_branch_pair(input int f3, input int rs1, input int rs2);
        prog.push_back(br_inst(f3, rs1, rs2, 8));
        prog.push_back(i_inst(0, 20, 0, prog.size()));
    endtask

    function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << b[4:0];
            3'd2:    r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            3'd3:    r = {31'b0, a < b};
            3'd4:    r = a ^ b;
            3'd5:    r = alt ? ((a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0))
                             : a >> b[4:0];
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("error %s %s: expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_reg_idx(input string what, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            $display("error %s %s: expected x%0d actual x%0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("error %s %s: expected %b actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // predict the retiring instruction, compare the trace, then commit
    task automatic step_and_check;
        word_t      inst;
        word_t      rs1v;
        word_t      rs2v;
        word_t      imm_i;
        word_t      addr;
        word_t      data;
        word_t      next_pc;
        reg_idx_t   rd;
        logic [2:0] f3;
        logic       wr;
        logic       taken;
        logic       lt;
        inst    = model_imem[model_pc[`RV_IMEM_AW+1:2]];
        rd      = inst[11:7];
        f3      = inst[14:12];
        rs1v    = model_regs[inst[19:15]];
        rs2v    = model_regs[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        wr      = 1'b0;
        taken   = 1'b0;
        data    = 32'h0;
        next_pc = model_pc + 32'd4;
        case (inst[6:0])
            7'b0110011: begin
                wr   = 1'b1;
                data = ref_alu(f3, inst[30], rs1v, rs2v);
            end
            7'b0010011: begin
                wr   = 1'b1;
                data = ref_alu(f3, inst[30] && (f3 == 3'd5), rs1v, imm_i);
            end
            7'b0000011: begin
                wr   = 1'b1;
                addr = rs1v + imm_i;
                data = model_dmem[addr[`RV_DMEM_AW+1:2]];
            end
            7'b0100011: begin
                addr = rs1v + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                model_dmem[addr[`RV_DMEM_AW+1:2]] = rs2v;
            end
            7'b1100011: begin
                lt = (rs1v[31] != rs2v[31]) ? rs1v[31] : (rs1v < rs2v); // signs decide first
                case (f3)
                    3'd0:    taken = (rs1v == rs2v);
                    3'd1:    taken = (rs1v != rs2v);
                    3'd4:    taken = lt;
                    3'd5:    taken = !lt;
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = model_pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                          inst[11:8], 1'b0};
                end
            end
            7'b0110111: begin
                wr   = 1'b1;
                data = {inst[31:12], 12'b0};
            end
            7'b1101111: begin
                wr      = 1'b1;
                data    = model_pc + 32'd4;    // link
                next_pc = model_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                      inst[30:21], 1'b0};
            end
            default: ;
        endcase
        check_word("pc", model_pc, pc);
        check_bit("wb.en", wr && (rd != 5'd0), wb.en);
        if (wr && (rd != 5'd0)) begin
            check_reg_idx("wb.rd", rd, wb.rd);
            check_word("wb.data", data, wb.data);
            model_regs[rd] = data;
        end
        halted   = (next_pc == model_pc);
        model_pc = next_pc;
    endtask

    // hold reset, write the program through the load port, release
    task automatic load_program;
        int i;
        @(posedge clk);
        #2;
        reset_b = 1'b0;
        for (i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            #2;
            prog_we   = 1'b1;
            prog_addr = imem_addr_t'(i);
            prog_data = prog[i];
            model_imem[imem_addr_t'(i)] = prog[i];
        end
        @(posedge clk);
        #2;
        prog_we = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        reset_b  = 1'b1;
        model_pc = `RV_RESET_PC;
    endtask

    // cycles > 0 runs exactly that many, else until the halt holds for 4 cycles
    task automatic run_program(input int cycles, input int limit);
        int n;
        int hold;
        n    = 0;
        hold = 0;
        while ((cycles > 0) ? (n < cycles) : (hold < 4)) begin
            if (n >= limit) begin
                $display("timeout in %s: program did not reach its halt loop within %0d cycles",
                         cur_test, limit);
                errors++;
                return;
            end
            @(negedge clk);
            step_and_check();
            hold = halted ? hold + 1 : 0;
            n++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test             = name;
        test_errors_at_start = errors;
        prog.delete();
    endtask

    task automatic finish_test;
        if (errors == test_errors_at_start) begin
            $display("test %s passed", cur_test);
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", cur_test, errors - test_errors_at_start);
            tests_failed++;
        end
    endtask

    task automatic test_rr_alu;
        word_t a;
        word_t b;
        start_test("rr_alu");
        a     = $random(seed);
        a[31] = 1'b1;                         // negative for sra and slt/sltu
        b     = $random(seed);
        b[31] = 1'b0;
        emit_li(1, a);
        emit_li(2, b);
        prog.push_back(rr_inst(0, 0, 3, 1, 2));      // add
        prog.push_back(rr_inst(32, 0, 4, 1, 2));     // sub
        prog.push_back(rr_inst(0, 7, 5, 1, 2));
        prog.push_back(rr_inst(0, 6, 6, 1, 2));
        prog.push_back(rr_inst(0, 4, 7, 1, 2));
        prog.push_back(rr_inst(0, 1, 8, 1, 2));
        prog.push_back(rr_inst(0, 5, 9, 1, 2));      // srl
        prog.push_back(rr_inst(32, 5, 10, 1, 2));    // sra
        prog.push_back(rr_inst(0, 2, 11, 1, 2));     // slt expects 1
        prog.push_back(rr_inst(0, 3, 12, 1, 2));     // sltu expects 0
        prog.push_back(jal_inst(0, 0));
        load_program();
        run_program(0, 64);
        finish_test();
    endtask

    task automatic test_imm_alu;
        word_t n;
        start_test("imm_alu");
        n     = $random(seed);
        n[31] = 1'b1;
        emit_li(1, n);
        emit_li(2, $random(seed) & 32'h7fff_ffff);
        prog.push_back(i_inst(0, 3, 1, -5));
        prog.push_back(i_inst(0, 4, 2, 1234));
        prog.push_back(i_inst(4, 5, 1, -1));         // xori with all ones inverts
        prog.push_back(i_inst(4, 18, 2, 1365));
        prog.push_back(i_inst(6, 6, 2, -256));
        prog.push_back(i_inst(6, 19, 1, 240));
        prog.push_back(i_inst(7, 7, 1, 2047));
        prog.push_back(i_inst(7, 8, 2, -16));
        prog.push_back(i_inst(2, 9, 1, -1));         // slti
        prog.push_back(i_inst(2, 10, 2, 5));
        prog.push_back(i_inst(3, 11, 2, -1));        // sltiu against all ones
        prog.push_back(i_inst(3, 12, 1, 7));
        prog.push_back(i_inst(1, 13, 1, 7));
        prog.push_back(i_inst(5, 14, 1, 13));
        prog.push_back(i_inst(5, 15, 1, 32'h400 | 13)); // srai
        prog.push_back(lui_inst(16, 32'hffff_f000));
        prog.push_back(lui_inst(17, 32'h1234_5000));
        prog.push_back(jal_inst(0, 0));
        load_program();
        run_program(0, 64);
        finish_test();
    endtask

    task automatic test_memory;
        start_test("memory");
        prog.push_back(i_inst(0, 1, 0, 64));         // base address
        emit_li(2, $random(seed));
        prog.push_back(sw_inst(2, 1, 0));
        emit_li(2, $random(seed));
        prog.push_back(sw_inst(2, 1, 12));
        emit_li(2, $random(seed));
        prog.push_back(sw_inst(2, 1, -32));
        emit_li(2, $random(seed));
        prog.push_back(sw_inst(2, 1, 100));
        prog.push_back(lw_inst(3, 1, 100));
        prog.push_back(lw_inst(4, 1, 0));
        prog.push_back(lw_inst(5, 1, -32));
        prog.push_back(lw_inst(6, 1, 12));
        prog.push_back(jal_inst(0, 0));
        load_program();
        run_program(0, 64);
        finish_test();
    endtask

    task automatic test_branches;
        start_test("branches");
        emit_li(1, 32'h7fff_ffff);
        emit_li(2, 32'h8000_0000);                   // x1 - x2 overflows
        prog.push_back(i_inst(0, 3, 0, 5));
        emit_branch_pair(0, 3, 3);                   // beq taken
        emit_branch_pair(0, 1, 2);
        emit_branch_pair(1, 1, 2);                   // bne taken
        emit_branch_pair(1, 3, 3);
        emit_branch_pair(4, 2, 1);                   // blt taken
        emit_branch_pair(4, 1, 2);
        emit_branch_pair(5, 1, 2);                   // bge taken
        emit_branch_pair(5, 2, 1);
        prog.push_back(jal_inst(0, 0));
        load_program();
        run_program(0, 64);
        finish_test();
    endtask

    task automatic test_jal_x0;
        start_test("jal_x0");
        prog.push_back(i_inst(0, 5, 0, 77));
        prog.push_back(i_inst(0, 0, 0, 5));          // aimed at x0
        prog.push_back(rr_inst(0, 0, 6, 0, 5));      // x0 must read zero
        prog.push_back(jal_inst(1, 12));
        prog.push_back(i_inst(0, 7, 0, 1));          // skipped
        prog.push_back(i_inst(0, 7, 0, 2));          // skipped
        prog.push_back(i_inst(0, 8, 1, 0));          // copy of the link
        prog.push_back(jal_inst(0, 0));
        load_program();
        run_program(0, 64);
        finish_test();
    endtask

    task automatic test_reset_mid_run;
        int i;
        start_test("reset_mid_run");
        prog.push_back(i_inst(0, 1, 1, 3));          // accumulates across the rerun
        prog.push_back(sw_inst(1, 0, 8));
        prog.push_back(lw_inst(2, 0, 8));
        prog.push_back(rr_inst(0, 0, 3, 2, 1));
        prog.push_back(i_inst(0, 4, 0, 9));
        prog.push_back(jal_inst(0, 0));
        load_program();
        run_program(3, 3);
        @(posedge clk);
        #2;
        reset_b = 1'b0;
        for (i = 0; i < 3; i++) begin
            @(negedge clk);
            check_bit("wb.en in reset", 1'b0, wb.en);
            check_word("pc in reset", `RV_RESET_PC, pc);
        end
        @(posedge clk);
        #2;
        reset_b  = 1'b1;
        model_pc = `RV_RESET_PC;
        run_program(0, 64);
        finish_test();
    endtask

    initial begin
        int i;
        reset_b      = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        halted       = 1'b0;
        model_pc     = `RV_RESET_PC;
        for (i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        test_rr_alu();
        test_imm_alu();
        test_memory();
        test_branches();
        test_jal_x0();
        test_reset_mid_run();
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- rv_core.sv
////////////////////
// Single-cycle RV32I subset core, one instruction per clock.
// pc and wb describe the instruction retiring this cycle.
// Reset low holds the pc and blocks all state writes.
// Load the program through prog_* while reset is low.
////////////////////
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset_b,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  word_t      prog_data,
    output word_t      pc,
    output wb_t        wb
);

    word_t      pc_plus4;
    word_t      inst;
    ctrl_t      ctrl;
    word_t      imm;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    alu_flags_t flags;
    word_t      mem_rdata;
    word_t      wb_data;
    logic       reg_we;
    logic       mem_we;

    rv_fetch u_fetch (
        .clk       (clk),
        .reset_b   (reset_b),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .branch    (ctrl.branch),
        .flags     (flags),
        .imm       (imm),
        .pc        (pc),
        .pc_plus4  (pc_plus4),
        .inst      (inst)
    );

    rv_decoder u_decoder (
        .inst (inst),
        .ctrl (ctrl),
        .imm  (imm)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .we       (reg_we),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rd       (ctrl.rd),
        .rd_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_a = ctrl.zero_a ? '0 : rs1_data;  // lui
    assign alu_b = ctrl.use_imm ? imm : rs2_data;

    rv_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .flags  (flags)
    );

    rv_data_mem u_data_mem (
        .clk   (clk),
        .we    (mem_we),
        .addr  (alu_result),
        .wdata (rs2_data),
        .rdata (mem_rdata)
    );

    always_comb begin
        case (ctrl.wb_sel)
            wb_mem:      wb_data = mem_rdata;
            wb_pc_plus4: wb_data = pc_plus4;   // jal link
            default:     wb_data = alu_result;
        endcase
    end

    assign reg_we = ctrl.reg_write && reset_b;
    assign mem_we = ctrl.mem_write && reset_b;

    assign wb.en   = reg_we && (ctrl.rd != '0);
    assign wb.rd   = ctrl.rd;
    assign wb.data = wb_data;

endmodule

//--- rv_data_mem.sv
////////////////////
// Word data memory, 2**RV_DMEM_AW words.
// Only aligned words: addr[1:0] and bits above the
// index are ignored. Contents are not reset.
////////////////////
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_data_mem import rv_pkg::*; (
    input  logic  clk,
    input  logic  we,
    input  word_t addr,
    input  word_t wdata,
    output word_t rdata
);

    localparam int DMEM_DEPTH = 1 << `RV_DMEM_AW;

    word_t                 mem [0:DMEM_DEPTH-1];
    logic [`RV_DMEM_AW-1:0] word_addr;

    assign word_addr = addr[`RV_DMEM_AW+1:2];
    assign rdata     = mem[word_addr];  // same-cycle load data

    always_ff @(posedge clk) begin
        if (we) begin
            mem[word_addr] <= wdata;
        end
    end

endmodule

//--- rv_fetch.sv
////////////////////
// Program counter and instruction memory.
// Instruction memory is read at pc[AW+1:2]; upper pc bits wrap.
// The load port writes one word per edge and is not blocked
// while the core runs.
////////////////////
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_fetch import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset_b,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  word_t      prog_data,
    input  branch_e    branch,
    input  alu_flags_t flags,
    input  word_t      imm,
    output word_t      pc,
    output word_t      pc_plus4,
    output word_t      inst
);

    localparam int IMEM_DEPTH = 1 << `RV_IMEM_AW;

    word_t      imem [0:IMEM_DEPTH-1];
    imem_addr_t fetch_addr;
    logic       redirect;
    word_t      pc_next;

    assign fetch_addr = pc[`RV_IMEM_AW+1:2];
    assign inst       = imem[fetch_addr];
    assign pc_plus4   = pc + word_t'(4);

    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_comb begin
        case (branch)
            br_beq:  redirect = flags.eq;
            br_bne:  redirect = !flags.eq;
            br_blt:  redirect = flags.lt_signed;
            br_bge:  redirect = !flags.lt_signed;
            br_jal:  redirect = 1'b1;
            default: redirect = 1'b0;
        endcase
    end

    assign pc_next = redirect ? (pc + imm) : pc_plus4; // imm already a byte offset

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

//--- rv_regfile.sv
////////////////////
// 32 x 32 register file, x1..x31 stored.
// Reads are combinational, the write lands on the rising edge.
// x0 reads zero and ignores writes. Contents are not reset.
////////////////////
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic     clk,
    input  logic     we,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  word_t    rd_data,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    word_t regs [1:31];

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (we && (rd != '0)) begin
            regs[rd] <= rd_data;
        end
    end

endmodule

//--- rv_alu.sv
////////////////////
// Combinational ALU.
// Shift amount is b[4:0]; flags compare a and b directly,
// so they are valid whatever op is selected.
////////////////////
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
    input  word_t      a,
    input  word_t      b,
    input  alu_op_e    op,
    output word_t      result,
    output alu_flags_t flags
);

    logic [4:0] shamt;
    logic       lt_unsigned;

    assign shamt           = b[4:0];
    assign lt_unsigned     = a < b;
    assign flags.eq        = a == b;
    assign flags.lt_signed = $signed(a) < $signed(b); // no overflow hazard

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_sll:    result = a << shamt;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = word_t'($signed(a) >>> shamt);
            alu_slt:    result = word_t'(flags.lt_signed);
            alu_sltu:   result = word_t'(lt_unsigned);
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

endmodule

//--- rv_decoder.sv
////////////////////
// Combinational decode of the kept RV32I subset.
// Unknown opcodes write nothing and never redirect.
// B and J immediates come out as byte offsets.
// Writes to x0 stay enabled here; the register file drops them.
////////////////////
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
    input  word_t inst,
    output ctrl_t ctrl,
    output word_t imm
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;        // funct7 bit 5 picks sub or sra
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt_sel);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt_sel ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt_sel ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl.rs1       = inst[19:15];
        ctrl.rs2       = inst[24:20];
        ctrl.rd        = inst[11:7];
        ctrl.alu_op    = alu_add;
        ctrl.use_imm   = 1'b0;
        ctrl.zero_a    = 1'b0;
        ctrl.reg_write = 1'b0;
        ctrl.mem_write = 1'b0;
        ctrl.wb_sel    = wb_alu;
        ctrl.branch    = br_none;
        imm            = '0;
        case (opcode)
            opc_op: begin
                ctrl.alu_op    = arith_op(funct3, alt);
                ctrl.reg_write = 1'b1;
            end
            opc_op_imm: begin
                ctrl.alu_op    = arith_op(funct3, alt && (funct3 == 3'b101)); // addi has no alt
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_i;  // sltiu compares this unsigned
            end
            opc_load: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_mem;
                imm            = imm_i;
            end
            opc_store: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                imm            = imm_s;
            end
            opc_branch: begin
                ctrl.alu_op = alu_sub;   // flags only
                imm         = imm_b;
                case (funct3)
                    3'b000:  ctrl.branch = br_beq;
                    3'b001:  ctrl.branch = br_bne;
                    3'b100:  ctrl.branch = br_blt;
                    3'b101:  ctrl.branch = br_bge;
                    default: ctrl.branch = br_none; // unsigned forms dropped
                endcase
            end
            opc_lui: begin
                ctrl.alu_op    = alu_pass_b;
                ctrl.use_imm   = 1'b1;
                ctrl.zero_a    = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_u;
            end
            opc_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_pc_plus4;
                ctrl.branch    = br_jal;
                imm            = imm_j;
            end
            default: ;
        endcase
    end

endmodule

//--- rv_pkg.sv
////////////////////
// Types for the RV32I subset core.
// Opcodes outside opcode_e decode as no-ops.
// Only signed branches and JAL redirect the pc.
////////////////////
`include "rv_macros.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]    word_t;
    typedef logic [4:0]             reg_idx_t;
    typedef logic [`RV_IMEM_AW-1:0] imem_addr_t;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_lui    = 7'b0110111,
        opc_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b      // lui result
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_jal
    } branch_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc_plus4
    } wb_sel_e;

    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        alu_op_e  alu_op;
        logic     use_imm;      // operand b from imm
        logic     zero_a;       // operand a forced to zero
        logic     reg_write;
        logic     mem_write;
        wb_sel_e  wb_sel;
        branch_e  branch;
    } ctrl_t;

    typedef struct packed {
        logic eq;
        logic lt_signed;
    } alu_flags_t;

    // retirement write trace
    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

//--- rv_macros.svh
////////////////////
// Width and reset constants shared by the package and the RTL.
// Memories are word addressed; depths are 2**AW words.
// RV_RESET_PC must be word aligned and inside the instruction memory.
////////////////////
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path width of 32 only
`define RV_XLEN 32

// instruction memory word-address width (256 words)
`define RV_IMEM_AW 8

// data memory word-address width (256 words)
`define RV_DMEM_AW 8

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
